// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pwo_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv bench/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/pwo_tb.sv ====
`timescale 1ns/1ps
`include "pwo_macros.svh"

module pwo_tb
    import pwo_pkg::*;
();

    localparam mem_addr_t BASE_A     = 15'h0040;
    localparam mem_addr_t BASE_B     = 15'h0100;
    localparam mem_addr_t BASE_C     = 15'h0200;
    localparam coeff_t    Q_MINUS_1  = coeff_t'(`PWO_Q - 1);
    localparam int        NUM_PASSES = 8;
    // Each pass takes about 80 cycles plus margin for setup and reset
    localparam int        TIMEOUT_NS = (NUM_PASSES * 80 + 200) * 8;

    logic      clk;
    logic      reset_n;
    pwo_op_e   mode;
    logic      accumulate;
    logic      enable;
    mem_word_t rd_data_a;
    mem_word_t rd_data_b;
    mem_word_t rd_data_c;
    mem_req_t  rd_req_a;
    mem_req_t  rd_req_b;
    mem_req_t  rd_req_c;
    mem_req_t  wr_req_c;
    mem_word_t wr_data_c;
    logic      busy;
    logic      done;

    mem_word_t mem_a [`PWO_WORDS];
    mem_word_t mem_b [`PWO_WORDS];
    mem_word_t mem_c [`PWO_WORDS];
    int        wr_hits [`PWO_WORDS];
    mem_word_t exp_data [$];
    int        exp_idx [$];
    int        exp_cycle [$];

    pwo_op_e cur_op = PWO_MUL;
    logic    cur_acc = 1'b0;
    logic    done_prev = 1'b0;
    integer  seed = 32'h92a4;
    int      reads, c_reads, writes, dones, cycle, last_wr;
    int      errors, err_mark, tests, failed_tests;

    tb_clock_gen i_clock_gen (.clk_o(clk), .reset_n_o(reset_n));

    pwo_top i_pwo_top (
        .clk(clk), .reset_n(reset_n), .mode_i(mode), .accumulate_i(accumulate),
        .enable_i(enable), .base_a_i(BASE_A), .base_b_i(BASE_B), .base_c_i(BASE_C),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b), .rd_data_c_i(rd_data_c),
        .rd_req_a_o(rd_req_a), .rd_req_b_o(rd_req_b), .rd_req_c_o(rd_req_c),
        .wr_req_c_o(wr_req_c), .wr_data_c_o(wr_data_c), .busy_o(busy), .done_o(done)
    );

    // ============================================================
    // Reference model
    // ============================================================

    function automatic coeff_t ref_coeff(input pwo_op_e op, input logic acc,
                                         input coeff_t a, input coeff_t b, input coeff_t c);
        longint unsigned q;
        longint unsigned r;
        q = 64'(`PWO_Q);
        case (op)
            PWO_MUL: r = (64'(a) * 64'(b) + (acc ? 64'(c) : 64'd0)) % q;
            PWO_ADD: r = (64'(a) + 64'(b)) % q;
            default: r = (64'(a) + q - 64'(b)) % q;
        endcase
        return coeff_t'(r);
    endfunction

    function automatic coeff_t slot(input mem_word_t w, input int s);
        return coeff_t'(w >> (s * `PWO_SLOT_WIDTH));
    endfunction

    // Expected write word with the spare top bit of each slot left zero
    function automatic mem_word_t ref_word(input pwo_op_e op, input logic acc,
                                           input mem_word_t a, input mem_word_t b,
                                           input mem_word_t c);
        mem_word_t w;
        w = '0;
        for (int s = 0; s < `PWO_LANES; s++) begin
            w = w | (mem_word_t'(ref_coeff(op, acc, slot(a, s), slot(b, s), slot(c, s)))
                     << (s * `PWO_SLOT_WIDTH));
        end
        return w;
    endfunction

    function automatic coeff_t rand_coeff();
        logic [31:0] r;
        r = $random(seed);
        return coeff_t'(r % 32'(`PWO_Q));
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic flag_problem(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    // ============================================================
    // Memory models and checker
    // ============================================================

    always @(posedge clk) begin
        if (rd_req_a.en) rd_data_a <= mem_a[rd_req_a.addr[5:0]];
        if (rd_req_b.en) rd_data_b <= mem_b[rd_req_b.addr[5:0]];
        if (rd_req_c.en) rd_data_c <= mem_c[rd_req_c.addr[5:0]];
        if (wr_req_c.en) mem_c[wr_req_c.addr[5:0]] <= wr_data_c;
    end

    always @(posedge clk) begin : compare
        int        k;
        int        rcyc;
        mem_word_t exp_w;
        cycle++;
        if (reset_n) begin
            assert (rd_req_c.en == (rd_req_a.en && cur_op == PWO_MUL && cur_acc))
            else flag_mismatch($sformatf("read-c enable is %b", rd_req_c.en));
            if (rd_req_a.en) begin
                k = reads;
                assert (rd_req_a.addr == BASE_A + mem_addr_t'(k) && rd_req_b.en && busy
                        && rd_req_b.addr == BASE_B + mem_addr_t'(k))
                else flag_mismatch($sformatf("read %0d at a=%h b=%h", k, rd_req_a.addr,
                                             rd_req_b.addr));
                if (rd_req_c.en) begin
                    assert (rd_req_c.addr == BASE_C + mem_addr_t'(k))
                    else flag_mismatch($sformatf("read-c %0d at %h", k, rd_req_c.addr));
                    c_reads++;
                end
                exp_data.push_back(ref_word(cur_op, cur_acc, mem_a[word_idx_t'(k)],
                                            mem_b[word_idx_t'(k)], mem_c[word_idx_t'(k)]));
                exp_idx.push_back(k);
                exp_cycle.push_back(cycle);
                reads++;
            end
            if (wr_req_c.en) begin
                wr_hits[word_idx_t'(wr_req_c.addr - BASE_C)]++;
                if (exp_data.size() == 0) begin
                    flag_problem("write request arrived with no read pending");
                end else begin
                    k = exp_idx.pop_front();
                    rcyc = exp_cycle.pop_front();
                    exp_w = exp_data.pop_front();
                    assert (wr_req_c.addr == BASE_C + mem_addr_t'(k))
                    else flag_mismatch($sformatf("word %0d written at %h", k, wr_req_c.addr));
                    assert (wr_data_c == exp_w)
                    else flag_mismatch($sformatf("word %0d data %h, expected %h", k,
                                                 wr_data_c, exp_w));
                    assert (cycle - rcyc == `PWO_WB_DELAY)
                    else flag_mismatch($sformatf("word %0d write %0d cycles after read", k,
                                                 cycle - rcyc));
                end
                writes++;
                last_wr = cycle;
            end
            if (done) begin
                dones++;
                assert (cycle == last_wr + 1 && busy)
                else flag_mismatch("done not in the cycle after the last write");
            end
            if (done_prev) begin
                assert (!busy) else flag_mismatch("busy still high after done");
            end
        end
        done_prev = done;
    end

    // ============================================================
    // Stimulus
    // ============================================================

    task automatic fill_operands(input logic edges);
        coeff_t va;
        coeff_t vb;
        for (int k = 0; k < `PWO_WORDS; k++) begin
            for (int s = 0; s < `PWO_LANES; s++) begin
                va = edges ? (((k + s) % 2 == 1) ? Q_MINUS_1 : '0) : rand_coeff();
                vb = edges ? ((($countones(k) + s) % 2 == 1) ? Q_MINUS_1 : '0) : rand_coeff();
                mem_a[k][s * `PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, va};
                mem_b[k][s * `PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, vb};
            end
        end
    endtask

    task automatic clear_c();
        for (int k = 0; k < `PWO_WORDS; k++) begin
            mem_c[k] <= '0;
        end
    endtask

    // One full pass with an optional stray enable while busy
    task automatic run_pass(input pwo_op_e op, input logic acc, input logic poke);
        int waited;
        reads = 0;
        c_reads = 0;
        writes = 0;
        dones = 0;
        exp_data.delete();
        exp_idx.delete();
        exp_cycle.delete();
        for (int k = 0; k < `PWO_WORDS; k++) wr_hits[k] = 0;
        cur_op = op;
        cur_acc = acc;
        mode <= op;
        accumulate <= acc;
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        if (poke) begin
            repeat (10) @(posedge clk);
            mode <= PWO_ADD;
            enable <= 1'b1;
            @(posedge clk);
            enable <= 1'b0;
        end
        waited = 0;
        while (!done && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (!done) flag_problem("no done pulse within 200 cycles");
        repeat (2) @(posedge clk);
        assert (reads == `PWO_WORDS && writes == `PWO_WORDS && dones == 1)
        else flag_mismatch($sformatf("%0d reads, %0d writes, %0d done pulses", reads, writes,
                                     dones));
        assert (c_reads == ((op == PWO_MUL && acc) ? `PWO_WORDS : 0))
        else flag_mismatch($sformatf("%0d reads of c", c_reads));
        for (int k = 0; k < `PWO_WORDS; k++) begin
            assert (wr_hits[k] == 1) else flag_mismatch($sformatf("word %0d written %0d times",
                                                                  k, wr_hits[k]));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %-22s ok", name);
        end else begin
            failed_tests++;
            $display("test %-22s %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        mode <= PWO_MUL;
        accumulate <= 1'b0;
        enable <= 1'b0;
        rd_data_a <= '0;
        rd_data_b <= '0;
        rd_data_c <= '0;
        clear_c();
        wait (reset_n === 1'b1);
        @(posedge clk);
        assert (!rd_req_a.en && !rd_req_b.en && !rd_req_c.en && !wr_req_c.en && !busy && !done)
        else flag_mismatch("outputs not idle after reset");
        end_test("reset_idle");

        fill_operands(1'b0);
        run_pass(PWO_ADD, 1'b0, 1'b0);
        end_test("pwa_random");
        fill_operands(1'b0);
        run_pass(PWO_SUB, 1'b0, 1'b0);
        end_test("pws_random");
        fill_operands(1'b0);
        run_pass(PWO_MUL, 1'b0, 1'b1);
        end_test("pwm_random_busy_enable");

        // Every combination of 0 and q-1 per slot
        fill_operands(1'b1);
        run_pass(PWO_ADD, 1'b0, 1'b0);
        end_test("pwa_edge");
        run_pass(PWO_SUB, 1'b0, 1'b0);
        end_test("pws_edge");
        run_pass(PWO_MUL, 1'b0, 1'b0);
        end_test("pwm_edge");

        fill_operands(1'b0);
        clear_c();
        @(posedge clk);
        run_pass(PWO_MUL, 1'b1, 1'b0);
        run_pass(PWO_MUL, 1'b1, 1'b0);
        for (int k = 0; k < `PWO_WORDS; k++) begin
            assert (mem_c[k] == ref_word(PWO_MUL, 1'b1, mem_a[k], mem_b[k],
                                         ref_word(PWO_MUL, 1'b0, mem_a[k], mem_b[k], '0)))
            else flag_mismatch($sformatf("word %0d of c after two accumulate passes", k));
        end
        end_test("pwm_accumulate_twice");

        $display("Tests run %0d, tests failed %0d, check errors %0d", tests, failed_tests,
                 errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        reset_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

// ==== include/pwo_macros.svh ====
`ifndef PWO_MACROS_SVH
`define PWO_MACROS_SVH

// ============================================================
// ML-DSA modulus and coefficient geometry
// ============================================================

`define PWO_Q             23'd8380417
`define PWO_COEFF_WIDTH   23
`define PWO_SLOT_WIDTH    24
`define PWO_LANES         4

// Memory layout of one polynomial
`define PWO_ADDR_WIDTH    15
`define PWO_WORDS         64

// Barrett reduction of a 46-bit product, m = floor(2^46 / q)
`define PWO_BARRETT_K     46
`define PWO_BARRETT_M     24'd8396807

// Pipeline depths
`define PWO_LANE_LATENCY  3
// Read request to write request, one memory cycle plus the lane
`define PWO_WB_DELAY      4

`endif

// ==== project.f ====
+incdir+include
source/pwo_pkg.sv
source/pwo_addr_gen.sv
source/pwo_mod_lane.sv
source/pwo_writeback.sv
source/pwo_top.sv
bench/tb_clock_gen.sv
bench/pwo_tb.sv

// ==== source/pwo_addr_gen.sv ====
`timescale 1ns/1ps
`include "pwo_macros.svh"

module pwo_addr_gen
    import pwo_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       enable_i,
    input  pwo_op_e    mode_i,
    input  logic       accumulate_i,
    input  mem_addr_t  base_a_i,
    input  mem_addr_t  base_b_i,
    input  mem_addr_t  base_c_i,
    input  logic       done_i,
    output mem_req_t   rd_req_a_o,
    output mem_req_t   rd_req_b_o,
    output mem_req_t   rd_req_c_o,
    output lane_ctrl_t ctrl_o,
    output issue_t     issue_o,
    output logic       busy_o
);

    localparam word_idx_t LAST_IDX = word_idx_t'(`PWO_WORDS - 1);

    pwo_state_e state_q;
    pwo_state_e state_d;
    word_idx_t  idx_q;
    lane_ctrl_t ctrl_q;
    mem_addr_t  base_a_q;
    mem_addr_t  base_b_q;
    mem_addr_t  base_c_q;
    mem_addr_t  offset;
    logic       start;
    logic       issuing;
    logic       last_idx;

    // Enable is only honoured while idle
    assign start    = (state_q == ST_IDLE) && enable_i;
    assign issuing  = (state_q == ST_ISSUE);
    assign last_idx = (idx_q == LAST_IDX);
    assign offset   = mem_addr_t'(idx_q);

    // ============================================================
    // State machine
    // ============================================================

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (enable_i) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                if (last_idx) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // Wait for the last write to leave the pipeline
                if (done_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            ctrl_q  <= '{op: PWO_MUL, add_c: 1'b0};
        end else begin
            state_q <= state_d;
            if (start) begin
                idx_q  <= '0;
                // Accumulate only has a meaning for multiply
                ctrl_q <= '{op: mode_i, add_c: (mode_i == PWO_MUL) && accumulate_i};
            end else if (issuing) begin
                idx_q <= idx_q + word_idx_t'(1);
            end
        end
    end

    // Base addresses for the pass
    always_ff @(posedge clk) begin
        if (start) begin
            base_a_q <= base_a_i;
            base_b_q <= base_b_i;
            base_c_q <= base_c_i;
        end
    end

    // ============================================================
    // Requests and issue records
    // ============================================================

    assign rd_req_a_o = '{en: issuing, addr: base_a_q + offset};
    assign rd_req_b_o = '{en: issuing, addr: base_b_q + offset};
    assign rd_req_c_o = '{en: issuing && ctrl_q.add_c, addr: base_c_q + offset};

    assign issue_o = '{valid: issuing, last: issuing && last_idx, addr: base_c_q + offset};
    assign ctrl_o  = ctrl_q;
    assign busy_o  = (state_q != ST_IDLE);

    // Old c words are only fetched for multiply with accumulate
    a_rd_c_only_acc : assert property (@(posedge clk) disable iff (!reset_n)
        $rose(rd_req_c_o.en) |-> (ctrl_q.op == PWO_MUL) && ctrl_q.add_c);

    // A pass always issues the whole polynomial
    a_issue_full_pass : assert property (@(posedge clk) disable iff (!reset_n)
        $fell(issuing) |-> (idx_q == '0));

endmodule

// ==== source/pwo_mod_lane.sv ====
`timescale 1ns/1ps
`include "pwo_macros.svh"

module pwo_mod_lane
    import pwo_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  lane_ctrl_t ctrl_i,
    input  coeff_t     a_i,
    input  coeff_t     b_i,
    input  coeff_t     c_i,
    output coeff_t     result_o
);

    localparam int PROD_W = 2 * `PWO_COEFF_WIDTH;
    localparam int BM_W   = `PWO_COEFF_WIDTH + 1;
    localparam int FULL_W = PROD_W + BM_W;
    // Barrett remainder is below 3q
    localparam int R_W    = `PWO_COEFF_WIDTH + 2;
    localparam int S_W    = `PWO_COEFF_WIDTH + 1;

    localparam logic [BM_W-1:0]   BARRETT_M = BM_W'(`PWO_BARRETT_M);
    localparam logic [FULL_W-1:0] Q_FULL    = FULL_W'(`PWO_Q);
    localparam logic [R_W-1:0]    Q_R       = R_W'(`PWO_Q);
    localparam logic [S_W-1:0]    Q_S       = S_W'(`PWO_Q);

    coeff_t             a1_q;
    coeff_t             b1_q;
    coeff_t             c1_q;
    logic [S_W-1:0]     sum;
    logic [S_W-1:0]     diff;
    coeff_t             lin;
    logic [PROD_W-1:0]  prod;
    logic [PROD_W-1:0]  prod2_q;
    coeff_t             lin2_q;
    coeff_t             c2_q;
    logic [FULL_W-1:0]  bar_full;
    logic [BM_W-1:0]    qhat;
    logic [FULL_W-1:0]  qq_full;
    logic [R_W-1:0]     rem;
    logic [R_W-1:0]     rem1;
    logic [R_W-1:0]     rem2;
    coeff_t             base;
    logic [S_W-1:0]     acc;
    coeff_t             result_q;

    // Stage 1 registers the operands
    always_ff @(posedge clk) begin
        a1_q <= a_i;
        b1_q <= b_i;
        c1_q <= c_i;
    end

    // ============================================================
    // Stage 2: product, or sum / difference with one correction
    // ============================================================

    always_comb begin
        sum  = S_W'(a1_q) + S_W'(b1_q);
        diff = S_W'(a1_q) - S_W'(b1_q);
        if (ctrl_i.op == PWO_SUB) begin
            // Wrap a negative difference back into range
            lin = (a1_q < b1_q) ? coeff_t'(diff + Q_S) : coeff_t'(diff);
        end else begin
            lin = (sum >= Q_S) ? coeff_t'(sum - Q_S) : coeff_t'(sum);
        end
        prod = PROD_W'(a1_q) * PROD_W'(b1_q);
    end

    always_ff @(posedge clk) begin
        prod2_q <= prod;
        lin2_q  <= lin;
        c2_q    <= c1_q;
    end

    // ============================================================
    // Stage 3: Barrett reduction and accumulate
    // ============================================================

    always_comb begin
        bar_full = FULL_W'(prod2_q) * FULL_W'(BARRETT_M);
        qhat     = bar_full[FULL_W-1:`PWO_BARRETT_K];
        qq_full  = FULL_W'(qhat) * Q_FULL;
        // Only the low bits matter, the true remainder is small
        rem  = prod2_q[R_W-1:0] - qq_full[R_W-1:0];
        rem1 = (rem >= Q_R) ? rem - Q_R : rem;
        rem2 = (rem1 >= Q_R) ? rem1 - Q_R : rem1;

        base = (ctrl_i.op == PWO_MUL) ? coeff_t'(rem2) : lin2_q;
        acc  = S_W'(base) + (ctrl_i.add_c ? S_W'(c2_q) : S_W'(0));
        if (acc >= Q_S) begin
            acc = acc - Q_S;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end else begin
            result_q <= coeff_t'(acc);
        end
    end

    assign result_o = result_q;

    // Fully reduced result whenever the lane carries real data
    a_result_reduced : assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(result_q) |-> (result_q < `PWO_Q));

endmodule

// ==== source/pwo_pkg.sv ====
`include "pwo_macros.svh"

package pwo_pkg;

    // ============================================================
    // Scalar types
    // ============================================================

    typedef logic [`PWO_COEFF_WIDTH-1:0]               coeff_t;
    typedef logic [`PWO_ADDR_WIDTH-1:0]                mem_addr_t;
    typedef logic [`PWO_LANES*`PWO_SLOT_WIDTH-1:0]     mem_word_t;
    typedef logic [$clog2(`PWO_WORDS)-1:0]             word_idx_t;

    // Pointwise operation selected for a pass
    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_op_e;

    // Address issuer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } pwo_state_e;

    // ============================================================
    // Structs
    // ============================================================

    // Read or write request to one memory port
    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    // Lane control, held for a whole pass
    typedef struct packed {
        pwo_op_e op;
        logic    add_c;
    } lane_ctrl_t;

    // One record per issued word, later turned into a write
    typedef struct packed {
        logic      valid;
        logic      last;
        mem_addr_t addr;
    } issue_t;

endpackage

// ==== source/pwo_top.sv ====
`timescale 1ns/1ps
`include "pwo_macros.svh"

module pwo_top
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  pwo_op_e   mode_i,
    input  logic      accumulate_i,
    input  logic      enable_i,
    input  mem_addr_t base_a_i,
    input  mem_addr_t base_b_i,
    input  mem_addr_t base_c_i,
    input  mem_word_t rd_data_a_i,
    input  mem_word_t rd_data_b_i,
    input  mem_word_t rd_data_c_i,
    output mem_req_t  rd_req_a_o,
    output mem_req_t  rd_req_b_o,
    output mem_req_t  rd_req_c_o,
    output mem_req_t  wr_req_c_o,
    output mem_word_t wr_data_c_o,
    output logic      busy_o,
    output logic      done_o
);

    lane_ctrl_t                  lane_ctrl;
    issue_t                      issue;
    coeff_t [`PWO_LANES-1:0]     lane_res;

    pwo_addr_gen i_addr_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .done_i       (done_o),
        .rd_req_a_o   (rd_req_a_o),
        .rd_req_b_o   (rd_req_b_o),
        .rd_req_c_o   (rd_req_c_o),
        .ctrl_o       (lane_ctrl),
        .issue_o      (issue),
        .busy_o       (busy_o)
    );

    // One lane per slot, the top bit of each slot is dropped
    for (genvar g = 0; g < `PWO_LANES; g++) begin : g_lane
        pwo_mod_lane i_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .ctrl_i   (lane_ctrl),
            .a_i      (rd_data_a_i[g*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH]),
            .b_i      (rd_data_b_i[g*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH]),
            .c_i      (rd_data_c_i[g*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH]),
            .result_o (lane_res[g])
        );
    end

    pwo_writeback i_writeback (
        .clk       (clk),
        .reset_n   (reset_n),
        .issue_i   (issue),
        .lane0_i   (lane_res[0]),
        .lane1_i   (lane_res[1]),
        .lane2_i   (lane_res[2]),
        .lane3_i   (lane_res[3]),
        .wr_req_o  (wr_req_c_o),
        .wr_data_o (wr_data_c_o),
        .done_o    (done_o)
    );

endmodule

// ==== source/pwo_writeback.sv ====
`timescale 1ns/1ps
`include "pwo_macros.svh"

module pwo_writeback
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  issue_t    issue_i,
    input  coeff_t    lane0_i,
    input  coeff_t    lane1_i,
    input  coeff_t    lane2_i,
    input  coeff_t    lane3_i,
    output mem_req_t  wr_req_o,
    output mem_word_t wr_data_o,
    output logic      done_o
);

    localparam int PAD_W = `PWO_SLOT_WIDTH - `PWO_COEFF_WIDTH;

    issue_t dly_q [`PWO_WB_DELAY];
    issue_t tail;
    logic   done_q;

    // ============================================================
    // Issue record delay line
    // ============================================================

    // Each record reaches the tail together with its lane results
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `PWO_WB_DELAY; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= issue_i;
            for (int i = 1; i < `PWO_WB_DELAY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign tail = dly_q[`PWO_WB_DELAY-1];

    // ============================================================
    // Write request and packing
    // ============================================================

    assign wr_req_o = '{en: tail.valid, addr: tail.addr};

    // Slot 0 in the low bits with the spare top bit of each slot zero
    assign wr_data_o = {
        {PAD_W{1'b0}}, lane3_i,
        {PAD_W{1'b0}}, lane2_i,
        {PAD_W{1'b0}}, lane1_i,
        {PAD_W{1'b0}}, lane0_i
    };

    // Done follows the last write by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= tail.valid && tail.last;
        end
    end

    assign done_o = done_q;

    a_done_single : assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o);

endmodule
